//--- tb.f
+incdir+include
verilog/udp_echo_pkg.sv
verilog/udp_port_filter.sv
verilog/payload_fifo.sv
verilog/udp_reply_builder.sv
verilog/udp_echo_core.sv
test/udp_echo_tb.sv

//--- include/udp_echo_tb_util.svh
// Testbench helpers for the echo core (random source, reply model, checker), included in the tb module
`ifndef UDP_ECHO_TB_UTIL_SVH
`define UDP_ECHO_TB_UTIL_SVH

// 16-bit Fibonacci LFSR, taps 16 14 13 11
// Steps once per bit taken, returns the bits MSB first
function automatic logic [31:0] lfsr_take(inout logic [15:0] state, input int unsigned nbits);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int unsigned i = 0; i < nbits; i++) begin
        fb    = state[15] ^ state[13] ^ state[12] ^ state[10];
        state = {state[14:0], fb};
        value = {value[30:0], fb};
    end
    return value;
endfunction

// Expected reply for a sent header
// Returns 0 when the frame is not for the echo port
function automatic bit ref_reply(
    input  logic [ADDR_WIDTH-1:0] source_ip,
    input  logic [PORT_WIDTH-1:0] source_port,
    input  logic [PORT_WIDTH-1:0] dest_port,
    input  logic [PORT_WIDTH-1:0] length,
    output logic [ADDR_WIDTH-1:0] exp_dest_ip,
    output logic [PORT_WIDTH-1:0] exp_source_port,
    output logic [PORT_WIDTH-1:0] exp_dest_port,
    output logic [PORT_WIDTH-1:0] exp_length
);
    exp_dest_ip     = source_ip;
    exp_source_port = dest_port;
    exp_dest_port   = source_port;
    exp_length      = length;
    return (dest_port == ECHO_PORT);
endfunction

// Compares one observed field with its expected value
task automatic check_equal(
    input  string       what,
    input  logic [63:0] got,
    input  logic [63:0] exp,
    inout  int          errors
);
    if (got !== exp) begin
        errors++;
        $display("[ERROR] %0t: %s mismatch, got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
endtask

`endif

//--- test/udp_echo_tb.sv
// Testbench of the UDP echo core, compiled through tb.f with udp_echo_tb as the top module
module udp_echo_tb import udp_echo_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int HDR_BITS       = ADDR_WIDTH + 3 * PORT_WIDTH;
    localparam int WAIT_HDR       = 0;
    localparam int WAIT_BYTE      = 1;
    localparam int WAIT_STALL     = 2;
    localparam int WAIT_DRAIN     = 3;

    logic                  clk;
    logic                  rst;
    logic                  in_hdr_valid;
    logic                  in_hdr_ready;
    logic [ADDR_WIDTH-1:0] in_source_ip;
    logic [PORT_WIDTH-1:0] in_source_port;
    logic [PORT_WIDTH-1:0] in_dest_port;
    logic [PORT_WIDTH-1:0] in_length;
    logic [DATA_WIDTH-1:0] in_payload_data;
    logic                  in_payload_valid;
    logic                  in_payload_ready;
    logic                  in_payload_last;
    logic                  in_payload_user;
    logic                  out_hdr_valid;
    logic                  out_hdr_ready;
    logic [ADDR_WIDTH-1:0] out_dest_ip;
    logic [PORT_WIDTH-1:0] out_source_port;
    logic [PORT_WIDTH-1:0] out_dest_port;
    logic [PORT_WIDTH-1:0] out_length;
    logic [DATA_WIDTH-1:0] out_payload_data;
    logic                  out_payload_valid;
    logic                  out_payload_ready;
    logic                  out_payload_last;
    logic                  out_payload_user;
    logic [DATA_WIDTH-1:0] led;

    // Expected replies, header as {ip, src port, dst port, length}, beat as {user, last, data}
    logic [HDR_BITS-1:0]   exp_hdr_q[$];
    logic [DATA_WIDTH+1:0] exp_pay_q[$];
    logic [DATA_WIDTH-1:0] exp_led;
    logic [15:0]           stim_lfsr;
    logic [15:0]           ready_lfsr;
    logic                  ready_random;
    logic                  hdr_ready_level;
    logic                  payload_ready_level;
    bit                    timed_out;
    int                    errors;
    int                    tests_run;
    int                    tests_bad;
    int                    hdr_seen;
    int                    bytes_seen;
    int                    frame_bytes_in;

    `include "udp_echo_tb_util.svh"

    udp_echo_core UUT (.*);

    always #50 clk = ~clk;

    // Output back-pressure, either fixed levels or random with 3 of 4 cycles ready
    always @(posedge clk) begin
        if (ready_random) begin
            out_hdr_ready     <= (lfsr_take(ready_lfsr, 2) != 0);
            out_payload_ready <= (lfsr_take(ready_lfsr, 2) != 0);
        end else begin
            out_hdr_ready     <= hdr_ready_level;
            out_payload_ready <= payload_ready_level;
        end
    end

    always @(posedge clk) begin : compare_outputs
        logic [HDR_BITS-1:0]   hdr;
        logic [DATA_WIDTH+1:0] beat;
        if (!rst && out_hdr_valid && out_hdr_ready) begin
            hdr_seen++;
            if (exp_hdr_q.size() == 0) begin
                errors++;
                $display("Reply header at time %0t was not expected", $time);
            end else begin
                hdr = exp_hdr_q.pop_front();
                check_equal("out_dest_ip", out_dest_ip, hdr[3*PORT_WIDTH +: ADDR_WIDTH], errors);
                check_equal("out_source_port", out_source_port, hdr[2*PORT_WIDTH +: PORT_WIDTH],
                            errors);
                check_equal("out_dest_port", out_dest_port, hdr[PORT_WIDTH +: PORT_WIDTH], errors);
                check_equal("out_length", out_length, hdr[0 +: PORT_WIDTH], errors);
            end
        end
        if (!rst && out_payload_valid && out_payload_ready) begin
            bytes_seen++;
            if (exp_pay_q.size() == 0) begin
                errors++;
                $display("Reply payload byte at time %0t was not expected", $time);
            end else begin
                beat = exp_pay_q.pop_front();
                check_equal("out_payload_data", out_payload_data, beat[DATA_WIDTH-1:0], errors);
                check_equal("out_payload_last", out_payload_last, beat[DATA_WIDTH], errors);
                check_equal("out_payload_user", out_payload_user, beat[DATA_WIDTH+1], errors);
            end
        end
    end

    // Each pass samples at a rising edge, so a handshake seen here has transferred
    task automatic wait_event(input int kind, input string what);
        int cycles;
        bit seen;
        cycles = 0;
        seen   = 1'b0;
        while (!timed_out && !seen) begin
            @(posedge clk);
            case (kind)
                WAIT_HDR:   seen = in_hdr_ready;
                WAIT_BYTE:  seen = in_payload_ready;
                WAIT_STALL: seen = in_payload_valid && !in_payload_ready;
                default:    seen = (exp_hdr_q.size() == 0) && (exp_pay_q.size() == 0);
            endcase
            cycles++;
            if (!seen && cycles >= TIMEOUT_CYCLES) begin
                timed_out = 1'b1;
                $display("Timeout after %0d cycles: %s", cycles, what);
            end
        end
    endtask

    task automatic send_frame(
        input logic [ADDR_WIDTH-1:0] sip,
        input logic [PORT_WIDTH-1:0] sport,
        input logic [PORT_WIDTH-1:0] dport,
        input int                    nbytes
    );
        logic [ADDR_WIDTH-1:0] e_ip;
        logic [PORT_WIDTH-1:0] e_sport;
        logic [PORT_WIDTH-1:0] e_dport;
        logic [PORT_WIDTH-1:0] e_len;
        logic [PORT_WIDTH-1:0] len;
        logic [DATA_WIDTH-1:0] data;
        logic                  user;
        bit                    match;
        // UDP length counts the 8 header bytes
        len   = PORT_WIDTH'(8 + nbytes);
        match = ref_reply(sip, sport, dport, len, e_ip, e_sport, e_dport, e_len);
        if (match) begin
            exp_hdr_q.push_back({e_ip, e_sport, e_dport, e_len});
        end
        frame_bytes_in = 0;
        in_hdr_valid   <= 1'b1;
        in_source_ip   <= sip;
        in_source_port <= sport;
        in_dest_port   <= dport;
        in_length      <= len;
        wait_event(WAIT_HDR, "input header was never accepted");
        in_hdr_valid <= 1'b0;
        for (int i = 0; i < nbytes; i++) begin
            data = DATA_WIDTH'(lfsr_take(stim_lfsr, DATA_WIDTH));
            user = lfsr_take(stim_lfsr, 1) != 0;
            if (match) begin
                exp_pay_q.push_back({user, i == nbytes - 1, data});
                if (i == 0) begin
                    exp_led = data;
                end
            end
            in_payload_valid <= 1'b1;
            in_payload_data  <= data;
            in_payload_last  <= (i == nbytes - 1);
            in_payload_user  <= user;
            wait_event(WAIT_BYTE, "input payload byte was never accepted");
            frame_bytes_in++;
        end
        in_payload_valid <= 1'b0;
    endtask

    task automatic close_test(input string name, input int errors_before);
        bit bad;
        bad = timed_out || (errors != errors_before);
        tests_run++;
        if (bad) begin
            tests_bad++;
        end
        $display("Test %0d %-24s %s", tests_run, name, bad ? "FAIL" : "ok");
    endtask

    initial begin : run_tests
        logic [DATA_WIDTH-1:0] led_before;
        logic [PORT_WIDTH-1:0] dport;
        int                    start_errs;
        int                    hdr_before;
        int                    bytes_before;
        clk = 1'b0;
        rst = 1'b1;
        in_hdr_valid = 1'b0;
        in_source_ip = '0;
        in_source_port = '0;
        in_dest_port = '0;
        in_length = '0;
        in_payload_data = '0;
        in_payload_valid = 1'b0;
        in_payload_last = 1'b0;
        in_payload_user = 1'b0;
        out_hdr_ready = 1'b0;
        out_payload_ready = 1'b0;
        ready_random = 1'b0;
        hdr_ready_level = 1'b1;
        payload_ready_level = 1'b1;
        stim_lfsr = 16'd85;
        ready_lfsr = 16'd85;
        exp_led = '0;
        timed_out = 1'b0;
        errors = 0;
        tests_run = 0;
        tests_bad = 0;
        hdr_seen = 0;
        bytes_seen = 0;
        frame_bytes_in = 0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        start_errs = errors;
        check_equal("out_hdr_valid", out_hdr_valid, 0, errors);
        check_equal("out_payload_valid", out_payload_valid, 0, errors);
        check_equal("in_hdr_ready", in_hdr_ready, 1, errors);
        check_equal("led", led, 0, errors);
        close_test("reset state", start_errs);

        start_errs = errors;
        hdr_before = hdr_seen;
        bytes_before = bytes_seen;
        send_frame({8'd192, 8'd168, 8'd1, 8'd20}, 16'd5000, ECHO_PORT, 6);
        wait_event(WAIT_DRAIN, "single echo reply did not come out");
        repeat (2) @(posedge clk);
        check_equal("reply headers", hdr_seen - hdr_before, 1, errors);
        check_equal("reply bytes", bytes_seen - bytes_before, 6, errors);
        check_equal("led", led, exp_led, errors);
        close_test("single echo frame", start_errs);

        start_errs = errors;
        led_before = led;
        hdr_before = hdr_seen;
        send_frame({8'd10, 8'd0, 8'd0, 8'd7}, 16'd4000, 16'd80, 12);
        // Observation window for any stray reply
        repeat (20) @(posedge clk);
        check_equal("reply headers", hdr_seen - hdr_before, 0, errors);
        check_equal("in_hdr_ready", in_hdr_ready, 1, errors);
        check_equal("led", led, led_before, errors);
        close_test("frame to other port", start_errs);

        start_errs = errors;
        ready_random <= 1'b1;
        for (int f = 0; f < 30; f++) begin
            dport = (lfsr_take(stim_lfsr, 1) != 0) ? ECHO_PORT
                                                    : PORT_WIDTH'(lfsr_take(stim_lfsr, 16));
            send_frame(lfsr_take(stim_lfsr, 32), PORT_WIDTH'(lfsr_take(stim_lfsr, 16)), dport,
                       1 + int'(lfsr_take(stim_lfsr, 6) % 40));
        end
        wait_event(WAIT_DRAIN, "random traffic replies did not all come out");
        ready_random <= 1'b0;
        repeat (2) @(posedge clk);
        check_equal("led", led, exp_led, errors);
        close_test("random mixed traffic", start_errs);

        start_errs = errors;
        bytes_before = bytes_seen;
        payload_ready_level <= 1'b0;
        @(posedge clk);
        fork
            send_frame({8'd172, 8'd16, 8'd0, 8'd9}, 16'd6000, ECHO_PORT, FIFO_DEPTH + 8);
            begin
                wait_event(WAIT_STALL, "input payload never stalled on a full FIFO");
                check_equal("bytes before stall", frame_bytes_in, FIFO_DEPTH, errors);
                check_equal("out_payload_valid", out_payload_valid, 1, errors);
                payload_ready_level <= 1'b1;
            end
        join
        wait_event(WAIT_DRAIN, "stalled frame did not drain");
        repeat (2) @(posedge clk);
        check_equal("reply bytes", bytes_seen - bytes_before, FIFO_DEPTH + 8, errors);
        close_test("payload back-pressure", start_errs);

        $display("%0d tests run, %0d failing, %0d check errors", tests_run, tests_bad, errors);
        if (errors == 0 && !timed_out) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- verilog/payload_fifo.sv
// Synchronous FIFO holding echo payload beats between the port filter and the reply builder
module payload_fifo import udp_echo_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,

    // Write side
    input  logic [DATA_WIDTH-1:0] wr_data,
    input  logic                  wr_valid,
    output logic                  wr_ready,
    input  logic                  wr_last,
    input  logic                  wr_user,

    // Read side
    output logic [DATA_WIDTH-1:0] rd_data,
    output logic                  rd_valid,
    input  logic                  rd_ready,
    output logic                  rd_last,
    output logic                  rd_user
);

    logic [DATA_WIDTH-1:0]   data_mem [FIFO_DEPTH];
    logic                    last_mem [FIFO_DEPTH];
    logic                    user_mem [FIFO_DEPTH];
    logic [FIFO_PTR_WIDTH:0] wr_ptr;
    logic [FIFO_PTR_WIDTH:0] rd_ptr;
    logic                    full;
    logic                    empty;
    logic                    wr_fire;
    logic                    rd_fire;

    // Same index, wrap bits differ when full
    assign full = (wr_ptr[FIFO_PTR_WIDTH] != rd_ptr[FIFO_PTR_WIDTH]) &&
                  (wr_ptr[FIFO_PTR_WIDTH-1:0] == rd_ptr[FIFO_PTR_WIDTH-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign wr_ready = !full;
    assign rd_valid = !empty;

    assign wr_fire = wr_valid && wr_ready;
    assign rd_fire = rd_valid && rd_ready;

    // Head of queue read straight from the array
    assign rd_data = data_mem[rd_ptr[FIFO_PTR_WIDTH-1:0]];
    assign rd_last = last_mem[rd_ptr[FIFO_PTR_WIDTH-1:0]];
    assign rd_user = user_mem[rd_ptr[FIFO_PTR_WIDTH-1:0]];

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            data_mem[wr_ptr[FIFO_PTR_WIDTH-1:0]] <= wr_data;
            last_mem[wr_ptr[FIFO_PTR_WIDTH-1:0]] <= wr_last;
            user_mem[wr_ptr[FIFO_PTR_WIDTH-1:0]] <= wr_user;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Write pointer holds across any cycle that started full
    a_no_write_full: assert property (@(posedge clk) disable iff (rst)
        $past(full) |-> wr_ptr == $past(wr_ptr))
        else $error("payload FIFO written while full");

    // Read pointer holds across any cycle that started empty
    a_no_read_empty: assert property (@(posedge clk) disable iff (rst)
        $past(empty) |-> rd_ptr == $past(rd_ptr))
        else $error("payload FIFO read while empty");

endmodule

//--- verilog/udp_echo_core.sv
// Top of the UDP echo block: port filter, payload FIFO and reply builder in a row
module udp_echo_core import udp_echo_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,

    // Parsed UDP header in
    input  logic                  in_hdr_valid,
    output logic                  in_hdr_ready,
    input  logic [ADDR_WIDTH-1:0] in_source_ip,
    input  logic [PORT_WIDTH-1:0] in_source_port,
    input  logic [PORT_WIDTH-1:0] in_dest_port,
    input  logic [PORT_WIDTH-1:0] in_length,

    // Payload in
    input  logic [DATA_WIDTH-1:0] in_payload_data,
    input  logic                  in_payload_valid,
    output logic                  in_payload_ready,
    input  logic                  in_payload_last,
    input  logic                  in_payload_user,

    // Reply header out
    output logic                  out_hdr_valid,
    input  logic                  out_hdr_ready,
    output logic [ADDR_WIDTH-1:0] out_dest_ip,
    output logic [PORT_WIDTH-1:0] out_source_port,
    output logic [PORT_WIDTH-1:0] out_dest_port,
    output logic [PORT_WIDTH-1:0] out_length,

    // Reply payload out
    output logic [DATA_WIDTH-1:0] out_payload_data,
    output logic                  out_payload_valid,
    input  logic                  out_payload_ready,
    output logic                  out_payload_last,
    output logic                  out_payload_user,

    output logic [DATA_WIDTH-1:0] led
);

    // Filter to builder
    logic                  hdr_slot_free;
    logic                  fwd_hdr_valid;
    logic [ADDR_WIDTH-1:0] fwd_dest_ip;
    logic [PORT_WIDTH-1:0] fwd_source_port;
    logic [PORT_WIDTH-1:0] fwd_dest_port;
    logic [PORT_WIDTH-1:0] fwd_length;

    // Filter to FIFO
    logic [DATA_WIDTH-1:0] fifo_in_data;
    logic                  fifo_in_valid;
    logic                  fifo_in_ready;
    logic                  fifo_in_last;
    logic                  fifo_in_user;

    // FIFO to builder
    logic [DATA_WIDTH-1:0] fifo_out_data;
    logic                  fifo_out_valid;
    logic                  fifo_out_ready;
    logic                  fifo_out_last;
    logic                  fifo_out_user;

    udp_port_filter filter_inst (
        .clk              (clk),
        .rst              (rst),
        .in_hdr_valid     (in_hdr_valid),
        .in_hdr_ready     (in_hdr_ready),
        .in_source_ip     (in_source_ip),
        .in_source_port   (in_source_port),
        .in_dest_port     (in_dest_port),
        .in_length        (in_length),
        .in_payload_data  (in_payload_data),
        .in_payload_valid (in_payload_valid),
        .in_payload_ready (in_payload_ready),
        .in_payload_last  (in_payload_last),
        .in_payload_user  (in_payload_user),
        .hdr_slot_free    (hdr_slot_free),
        .fwd_hdr_valid    (fwd_hdr_valid),
        .fwd_dest_ip      (fwd_dest_ip),
        .fwd_source_port  (fwd_source_port),
        .fwd_dest_port    (fwd_dest_port),
        .fwd_length       (fwd_length),
        .fifo_in_data     (fifo_in_data),
        .fifo_in_valid    (fifo_in_valid),
        .fifo_in_ready    (fifo_in_ready),
        .fifo_in_last     (fifo_in_last),
        .fifo_in_user     (fifo_in_user)
    );

    payload_fifo fifo_inst (
        .clk      (clk),
        .rst      (rst),
        .wr_data  (fifo_in_data),
        .wr_valid (fifo_in_valid),
        .wr_ready (fifo_in_ready),
        .wr_last  (fifo_in_last),
        .wr_user  (fifo_in_user),
        .rd_data  (fifo_out_data),
        .rd_valid (fifo_out_valid),
        .rd_ready (fifo_out_ready),
        .rd_last  (fifo_out_last),
        .rd_user  (fifo_out_user)
    );

    udp_reply_builder builder_inst (
        .clk               (clk),
        .rst               (rst),
        .fwd_hdr_valid     (fwd_hdr_valid),
        .fwd_dest_ip       (fwd_dest_ip),
        .fwd_source_port   (fwd_source_port),
        .fwd_dest_port     (fwd_dest_port),
        .fwd_length        (fwd_length),
        .hdr_slot_free     (hdr_slot_free),
        .fifo_out_data     (fifo_out_data),
        .fifo_out_valid    (fifo_out_valid),
        .fifo_out_ready    (fifo_out_ready),
        .fifo_out_last     (fifo_out_last),
        .fifo_out_user     (fifo_out_user),
        .out_hdr_valid     (out_hdr_valid),
        .out_hdr_ready     (out_hdr_ready),
        .out_dest_ip       (out_dest_ip),
        .out_source_port   (out_source_port),
        .out_dest_port     (out_dest_port),
        .out_length        (out_length),
        .out_payload_data  (out_payload_data),
        .out_payload_valid (out_payload_valid),
        .out_payload_ready (out_payload_ready),
        .out_payload_last  (out_payload_last),
        .out_payload_user  (out_payload_user),
        .led               (led)
    );

endmodule

//--- verilog/udp_echo_pkg.sv
// Shared widths, constants and state type of the UDP echo core, imported by every RTL block
package udp_echo_pkg;

    // Payload stream is one byte per beat
    localparam int DATA_WIDTH = 8;

    // UDP ports and the UDP length field
    localparam int PORT_WIDTH = 16;

    // IPv4 addresses
    localparam int ADDR_WIDTH = 32;

    // Only frames sent to this port are echoed
    localparam logic [PORT_WIDTH-1:0] ECHO_PORT = PORT_WIDTH'(1234);

    // Own address, 192.168.1.128
    // The outer stack puts it in as the reply source
    localparam logic [ADDR_WIDTH-1:0] LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};

    // Time to live of every reply, filled in by the outer stack
    localparam logic [7:0] REPLY_TTL = 8'd64;

    // Payload FIFO entries
    // Small on purpose so that back-pressure reaches the input quickly
    // Must be a power of two, the pointers wrap on their own
    localparam int FIFO_DEPTH = 16;

    // Index width into the FIFO, the pointers carry one extra wrap bit
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);

    // Port filter states
    // FILT_IDLE waits for the next header
    // FILT_FORWARD steers payload into the FIFO until the last byte
    // FILT_DISCARD swallows payload until the last byte
    typedef enum logic [1:0] {
        FILT_IDLE    = 2'd0,
        FILT_FORWARD = 2'd1,
        FILT_DISCARD = 2'd2
    } filter_state_t;

endpackage

//--- verilog/udp_port_filter.sv
// Port filter of the echo core: claims headers sent to the echo port and steers their payload
module udp_port_filter import udp_echo_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,

    // Parsed UDP header from the stack
    input  logic                  in_hdr_valid,
    output logic                  in_hdr_ready,
    input  logic [ADDR_WIDTH-1:0] in_source_ip,
    input  logic [PORT_WIDTH-1:0] in_source_port,
    input  logic [PORT_WIDTH-1:0] in_dest_port,
    input  logic [PORT_WIDTH-1:0] in_length,

    // Payload of the same frame
    input  logic [DATA_WIDTH-1:0] in_payload_data,
    input  logic                  in_payload_valid,
    output logic                  in_payload_ready,
    input  logic                  in_payload_last,
    input  logic                  in_payload_user,

    // Reply header handed to the builder
    input  logic                  hdr_slot_free,
    output logic                  fwd_hdr_valid,
    output logic [ADDR_WIDTH-1:0] fwd_dest_ip,
    output logic [PORT_WIDTH-1:0] fwd_source_port,
    output logic [PORT_WIDTH-1:0] fwd_dest_port,
    output logic [PORT_WIDTH-1:0] fwd_length,

    // Payload toward the FIFO
    output logic [DATA_WIDTH-1:0] fifo_in_data,
    output logic                  fifo_in_valid,
    input  logic                  fifo_in_ready,
    output logic                  fifo_in_last,
    output logic                  fifo_in_user
);

    filter_state_t state;
    filter_state_t state_next;
    logic          hdr_match;
    logic          hdr_fire;
    logic          payload_fire;

    assign hdr_match = (in_dest_port == ECHO_PORT);

    // A matching header also needs room in the builder
    assign in_hdr_ready = (state == FILT_IDLE) && (hdr_slot_free || !hdr_match);
    assign hdr_fire     = in_hdr_valid && in_hdr_ready;

    // Reply goes back to the peer, ports swapped
    assign fwd_hdr_valid   = hdr_fire && hdr_match;
    assign fwd_dest_ip     = in_source_ip;
    assign fwd_source_port = in_dest_port;
    assign fwd_dest_port   = in_source_port;
    assign fwd_length      = in_length;

    always_comb begin
        case (state)
            FILT_FORWARD: in_payload_ready = fifo_in_ready;
            FILT_DISCARD: in_payload_ready = 1'b1;
            default:      in_payload_ready = 1'b0;
        endcase
    end

    assign payload_fire = in_payload_valid && in_payload_ready;

    assign fifo_in_data  = in_payload_data;
    assign fifo_in_valid = in_payload_valid && (state == FILT_FORWARD);
    assign fifo_in_last  = in_payload_last;
    assign fifo_in_user  = in_payload_user;

    always_comb begin
        state_next = state;
        case (state)
            FILT_IDLE: begin
                if (hdr_fire && hdr_match) begin
                    state_next = FILT_FORWARD;
                end else if (hdr_fire) begin
                    state_next = FILT_DISCARD;
                end
            end
            FILT_FORWARD, FILT_DISCARD: begin
                // Back to idle once the final byte is gone
                if (payload_fire && in_payload_last) begin
                    state_next = FILT_IDLE;
                end
            end
            default: state_next = FILT_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FILT_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // The builder must have a free slot for every header handed over
    a_fwd_needs_slot: assert property (@(posedge clk) disable iff (rst)
        fwd_hdr_valid |-> hdr_slot_free)
        else $error("reply header handed over while the builder slot is taken");

    // A beat offered to a full FIFO stays offered until it is written
    a_hold_while_full: assert property (@(posedge clk) disable iff (rst)
        fifo_in_valid && !fifo_in_ready |=>
            fifo_in_valid && $stable({fifo_in_data, fifo_in_last, fifo_in_user}))
        else $error("payload beat dropped or changed while the FIFO was full");

endmodule

//--- verilog/udp_reply_builder.sv
// Reply side of the echo core: holds one reply header, streams the FIFO out and drives the LEDs
module udp_reply_builder import udp_echo_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,

    // Reply header from the port filter
    input  logic                  fwd_hdr_valid,
    input  logic [ADDR_WIDTH-1:0] fwd_dest_ip,
    input  logic [PORT_WIDTH-1:0] fwd_source_port,
    input  logic [PORT_WIDTH-1:0] fwd_dest_port,
    input  logic [PORT_WIDTH-1:0] fwd_length,
    output logic                  hdr_slot_free,

    // Buffered payload
    input  logic [DATA_WIDTH-1:0] fifo_out_data,
    input  logic                  fifo_out_valid,
    output logic                  fifo_out_ready,
    input  logic                  fifo_out_last,
    input  logic                  fifo_out_user,

    // Reply header toward the stack
    output logic                  out_hdr_valid,
    input  logic                  out_hdr_ready,
    output logic [ADDR_WIDTH-1:0] out_dest_ip,
    output logic [PORT_WIDTH-1:0] out_source_port,
    output logic [PORT_WIDTH-1:0] out_dest_port,
    output logic [PORT_WIDTH-1:0] out_length,

    // Reply payload toward the stack
    output logic [DATA_WIDTH-1:0] out_payload_data,
    output logic                  out_payload_valid,
    input  logic                  out_payload_ready,
    output logic                  out_payload_last,
    output logic                  out_payload_user,

    output logic [DATA_WIDTH-1:0] led
);

    logic first_beat;
    logic payload_fire;

    // Slot frees in the cycle the held header is taken
    assign hdr_slot_free = !out_hdr_valid || out_hdr_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_hdr_valid <= 1'b0;
        end else if (fwd_hdr_valid) begin
            out_hdr_valid <= 1'b1;
        end else if (out_hdr_ready) begin
            out_hdr_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fwd_hdr_valid) begin
            out_dest_ip     <= fwd_dest_ip;
            out_source_port <= fwd_source_port;
            out_dest_port   <= fwd_dest_port;
            out_length      <= fwd_length;
        end
    end

    // Payload goes out as it leaves the FIFO
    assign out_payload_data  = fifo_out_data;
    assign out_payload_valid = fifo_out_valid;
    assign out_payload_last  = fifo_out_last;
    assign out_payload_user  = fifo_out_user;
    assign fifo_out_ready    = out_payload_ready;

    assign payload_fire = fifo_out_valid && out_payload_ready;

    // First transferred byte of every frame goes to the LEDs
    always_ff @(posedge clk) begin
        if (rst) begin
            first_beat <= 1'b1;
            led        <= '0;
        end else if (payload_fire) begin
            if (first_beat) begin
                led <= fifo_out_data;
            end
            // Next beat starts a new frame after a last
            first_beat <= fifo_out_last;
        end
    end

    // A waiting reply header must not change under the stack
    a_hdr_stable: assert property (@(posedge clk) disable iff (rst)
        out_hdr_valid && !out_hdr_ready |=>
            out_hdr_valid &&
            $stable({out_dest_ip, out_source_port, out_dest_port, out_length}))
        else $error("reply header changed while waiting for out_hdr_ready");

endmodule
